// ==== hdl/saturnBusPkg.sv ====
package saturnBusPkg;

	// Main bus widths
	typedef logic [26:0] busAddr;
	typedef logic [31:0] busData;
	typedef logic [3:0]  byteMask;   // Bit 3 is the top byte
	typedef logic [7:0]  smpcData;

	parameter int laneCount = 4;

	// CPU side of the bus, held steady while waitN is low
	typedef struct packed {
		busAddr  addr;
		busData  wdata;
		byteMask lanes;
		logic    rd;
		logic    wr;
	} cpuReq;

	typedef struct packed {
		busData rdata;
		logic   waitN;   // Low stalls the CPU
	} cpuRsp;

endpackage

// ==== hdl/saturnMapPkg.sv ====
package saturnMapPkg;

	typedef enum logic [2:0] {
		regNone,
		regRom,
		regSram,
		regSmpc,
		regLoRam,
		regScu,
		regHiRam
	} region;

	// Inclusive bounds of each region
	parameter saturnBusPkg::busAddr romBase   = 27'h0000000;
	parameter saturnBusPkg::busAddr romTop    = 27'h00FFFFF;
	parameter saturnBusPkg::busAddr smpcBase  = 27'h0100000;
	parameter saturnBusPkg::busAddr smpcTop   = 27'h017FFFF;
	parameter saturnBusPkg::busAddr sramBase  = 27'h0180000;
	parameter saturnBusPkg::busAddr sramTop   = 27'h01FFFFF;
	parameter saturnBusPkg::busAddr loRamBase = 27'h0200000;
	parameter saturnBusPkg::busAddr loRamTop  = 27'h02FFFFF;
	parameter saturnBusPkg::busAddr scuBase   = 27'h5FE0000;
	parameter saturnBusPkg::busAddr scuTop    = 27'h5FEFFFF;
	parameter saturnBusPkg::busAddr hiRamBase = 27'h6000000;
	parameter saturnBusPkg::busAddr hiRamTop  = 27'h7FFFFFF;

	// SMPC is byte wide, upper bits read back as this pattern
	parameter logic [23:0] smpcPad = 24'h0000FF;

endpackage

// ==== hdl/regionDecoder.sv ====
`timescale 1ns/1ns

module regionDecoder (
	input  saturnBusPkg::busAddr addr,
	input  logic                 rd,
	input  logic                 wr,
	output saturnMapPkg::region  hit,
	output logic                 romCsN,
	output logic                 sramCsN,
	output logic                 ramLCsN,
	output logic                 ramHCsN,
	output logic                 memRdN
);

	saturnMapPkg::region match;
	logic memRegion;

	function automatic logic inRange(
		input saturnBusPkg::busAddr a,
		input saturnBusPkg::busAddr lo,
		input saturnBusPkg::busAddr hi
	);
		return (a >= lo) && (a <= hi);
	endfunction

	always_comb begin
		if (inRange(addr, saturnMapPkg::romBase, saturnMapPkg::romTop)) begin
			match = saturnMapPkg::regRom;
		end else if (inRange(addr, saturnMapPkg::smpcBase, saturnMapPkg::smpcTop)) begin
			match = saturnMapPkg::regSmpc;
		end else if (inRange(addr, saturnMapPkg::sramBase, saturnMapPkg::sramTop)) begin
			match = saturnMapPkg::regSram;
		end else if (inRange(addr, saturnMapPkg::loRamBase, saturnMapPkg::loRamTop)) begin
			match = saturnMapPkg::regLoRam;
		end else if (inRange(addr, saturnMapPkg::scuBase, saturnMapPkg::scuTop)) begin
			match = saturnMapPkg::regScu;
		end else if (inRange(addr, saturnMapPkg::hiRamBase, saturnMapPkg::hiRamTop)) begin
			match = saturnMapPkg::regHiRam;
		end else begin
			match = saturnMapPkg::regNone;
		end
	end

	// No region without a strobe
	assign hit = (rd || wr) ? match : saturnMapPkg::regNone;

	assign romCsN  = (hit != saturnMapPkg::regRom);
	assign sramCsN = (hit != saturnMapPkg::regSram);
	assign ramLCsN = (hit != saturnMapPkg::regLoRam);
	assign ramHCsN = (hit != saturnMapPkg::regHiRam);

	// External memory only, SMPC and SCU have their own read paths
	assign memRegion = !romCsN || !sramCsN || !ramLCsN || !ramHCsN;
	assign memRdN    = !(rd && memRegion);

endmodule

// ==== hdl/openBusLatch.sv ====
`timescale 1ns/1ns

module openBusLatch (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 sysResN,
	input  saturnBusPkg::busData  wdata,
	input  saturnBusPkg::byteMask lanes,
	input  saturnBusPkg::busData  rdCapture,
	input  logic                 captureRead,
	input  logic                 captureWrite,
	output saturnBusPkg::busData  openBus,
	output saturnBusPkg::busData  mergedWdata
);

	saturnBusPkg::busData busReg;

	// Unwritten lanes carry the last bus value
	always_comb begin
		for (int i = 0; i < saturnBusPkg::laneCount; i++) begin
			if (lanes[i]) begin
				mergedWdata[i*8 +: 8] = wdata[i*8 +: 8];
			end else begin
				mergedWdata[i*8 +: 8] = busReg[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busReg <= '1;
		end else if (sysResN) begin   // Frozen during system reset
			if (captureRead) begin
				busReg <= rdCapture;
			end else if (captureWrite) begin
				busReg <= mergedWdata;   // Only enabled lanes change
			end
		end
	end

	assign openBus = busReg;

endmodule

// ==== hdl/readDataSelect.sv ====
`timescale 1ns/1ns

module readDataSelect #(
	parameter bit hiRamSlow = 1'b0
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  saturnMapPkg::region  hit,
	input  logic                 rd,
	input  logic                 wr,
	input  saturnBusPkg::busData  openBus,
	input  saturnBusPkg::busData  memRdata,
	input  logic                 memWaitN,
	input  saturnBusPkg::smpcData smpcRdata,
	input  saturnBusPkg::busData  scuRdata,
	input  logic                 scuWaitN,
	output saturnBusPkg::cpuRsp   rsp,
	output logic                 captureRead,
	output logic                 captureWrite
);

	typedef enum logic {
		idle,
		slowWait
	} accessState;

	accessState state;
	accessState stateNext;
	logic memRegion;
	logic slowStall;
	logic waitN;

	assign memRegion = (hit == saturnMapPkg::regRom) || (hit == saturnMapPkg::regSram) ||
		(hit == saturnMapPkg::regLoRam) || (hit == saturnMapPkg::regHiRam);

	// First cycle of a slow high RAM access
	assign slowStall = hiRamSlow && (hit == saturnMapPkg::regHiRam) && (state == idle);

	// SCU wait applies to every access
	assign waitN = scuWaitN && (memWaitN || !memRegion) && !slowStall;

	always_comb begin
		unique case (hit)
			saturnMapPkg::regRom,
			saturnMapPkg::regSram,
			saturnMapPkg::regLoRam,
			saturnMapPkg::regHiRam: rsp.rdata = memRdata;
			saturnMapPkg::regSmpc:  rsp.rdata = {saturnMapPkg::smpcPad, smpcRdata};
			saturnMapPkg::regScu:   rsp.rdata = scuRdata;
			default:                rsp.rdata = openBus;   // Unmapped
		endcase
		rsp.waitN = waitN;
	end

	assign captureRead  = rd && waitN;
	assign captureWrite = wr && waitN;

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (slowStall) begin
					stateNext = slowWait;
				end
			end
			slowWait: begin
				// Back to idle once the access ends or is dropped
				if (!(rd || wr) || waitN) begin
					stateNext = idle;
				end
			end
			default: stateNext = idle;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= idle;
		end else begin
			state <= stateNext;
		end
	end

endmodule

// ==== hdl/saturnBusGlue.sv ====
`timescale 1ns/1ns

module saturnBusGlue #(
	parameter bit hiRamSlow = 1'b0
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 sysResN,
	input  saturnBusPkg::cpuReq   req,
	input  saturnBusPkg::busData  memRdata,
	input  logic                 memWaitN,
	input  saturnBusPkg::smpcData smpcRdata,
	input  saturnBusPkg::busData  scuRdata,
	input  logic                 scuWaitN,
	output saturnBusPkg::cpuRsp   rsp,
	output logic                 romCsN,
	output logic                 sramCsN,
	output logic                 ramLCsN,
	output logic                 ramHCsN,
	output saturnBusPkg::busData  memWdata,
	output saturnBusPkg::byteMask memLanes,
	output logic                 memRdN
);

	saturnMapPkg::region hit;
	saturnBusPkg::busData openBus;
	logic captureRead;
	logic captureWrite;

	assign memLanes = req.lanes;

	regionDecoder decoder0 (
		.addr    (req.addr),
		.rd      (req.rd),
		.wr      (req.wr),
		.hit     (hit),
		.romCsN  (romCsN),
		.sramCsN (sramCsN),
		.ramLCsN (ramLCsN),
		.ramHCsN (ramHCsN),
		.memRdN  (memRdN)
	);

	openBusLatch latch0 (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.sysResN      (sysResN),
		.wdata        (req.wdata),
		.lanes        (req.lanes),
		.rdCapture    (rsp.rdata),   // CPU read data as returned
		.captureRead  (captureRead),
		.captureWrite (captureWrite),
		.openBus      (openBus),
		.mergedWdata  (memWdata)
	);

	readDataSelect #(
		.hiRamSlow (hiRamSlow)
	) select0 (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.hit          (hit),
		.rd           (req.rd),
		.wr           (req.wr),
		.openBus      (openBus),
		.memRdata     (memRdata),
		.memWaitN     (memWaitN),
		.smpcRdata    (smpcRdata),
		.scuRdata     (scuRdata),
		.scuWaitN     (scuWaitN),
		.rsp          (rsp),
		.captureRead  (captureRead),
		.captureWrite (captureWrite)
	);

endmodule

// ==== tb/saturnBusGlueTb.sv ====
`timescale 1ns/1ns

module saturnBusGlueTb;

	localparam int resetCycles = 2;
	localparam int maxPatterns = 64;

	// One access from the pattern file
	typedef struct packed {
		logic [3:0]            op;   // 0 read, 1 write, 2 write in system reset
		saturnBusPkg::busAddr  addr;
		saturnBusPkg::byteMask lanes;
		saturnBusPkg::busData  wdata;
		saturnBusPkg::busData  memRdata;
		saturnBusPkg::smpcData smpcRdata;
		saturnBusPkg::busData  scuRdata;
		logic [7:0]            memWait;
		saturnBusPkg::busData  expData;   // rdata on reads, memWdata on writes
		logic [3:0]            expCs;     // rom, sram, ramL, ramH
		saturnBusPkg::busData  expOpenBus;
	} patternLine;

	logic CLK;
	logic RST_N;
	logic sysResN;
	saturnBusPkg::cpuReq   req;
	saturnBusPkg::busData  memRdata;
	logic                  memWaitN;
	saturnBusPkg::smpcData smpcRdata;
	saturnBusPkg::busData  scuRdata;
	logic                  scuWaitN;
	saturnBusPkg::cpuRsp   rsp;
	logic romCsN;
	logic sramCsN;
	logic ramLCsN;
	logic ramHCsN;
	saturnBusPkg::busData  memWdata;
	saturnBusPkg::byteMask memLanes;
	logic memRdN;

	patternLine pats [0:maxPatterns-1];
	int patCount = 0;
	int errors = 0;
	int testsFailed = 0;
	int cycles = 0;
	int cycleLimit = 0;

	saturnBusGlue #(
		.hiRamSlow (1'b1)
	) dut0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.sysResN   (sysResN),
		.req       (req),
		.memRdata  (memRdata),
		.memWaitN  (memWaitN),
		.smpcRdata (smpcRdata),
		.scuRdata  (scuRdata),
		.scuWaitN  (scuWaitN),
		.rsp       (rsp),
		.romCsN    (romCsN),
		.sramCsN   (sramCsN),
		.ramLCsN   (ramLCsN),
		.ramHCsN   (ramHCsN),
		.memWdata  (memWdata),
		.memLanes  (memLanes),
		.memRdN    (memRdN)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic readPatterns();
		int fd;
		int n;
		int status;
		string line;
		logic [3:0] op;
		logic [26:0] addr;
		logic [3:0] lanes;
		logic [31:0] wdata;
		logic [31:0] memRd;
		logic [7:0] smpcRd;
		logic [31:0] scuRd;
		logic [7:0] memWait;
		logic [31:0] expData;
		logic [3:0] expCs;
		logic [31:0] expOb;
		fd = $fopen("tb/saturnBusGluePatterns.txt", "r");
		if (fd == 0) begin
			$display("the pattern file could not be opened");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			status = $fgets(line, fd);
			if (status != 0 && line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", op, addr, lanes, wdata,
					memRd, smpcRd, scuRd, memWait, expData, expCs, expOb);
				if (n == 11 && patCount < maxPatterns) begin
					pats[patCount] = {op, addr, lanes, wdata, memRd, smpcRd, scuRd, memWait,
						expData, expCs, expOb};
					patCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	function automatic string opName(input logic [3:0] op);
		if (op == 4'd0) begin
			return "read";
		end else if (op == 4'd1) begin
			return "write";
		end
		return "write in system reset";
	endfunction

	// Bus idle means no chip select and no memory read
	task automatic checkIdle();
		checkValue("idle chip selects", {28'd0, romCsN, sramCsN, ramLCsN, ramHCsN}, 32'hF);
		checkValue("idle memRdN", {31'd0, memRdN}, 32'h1);
	endtask

	task automatic runAccess(input int idx);
		patternLine p;
		int stall;
		int expStall;
		int waitLen;
		int errorsBefore;
		logic memAccess;
		p = pats[idx];
		errorsBefore = errors;
		waitLen = {24'd0, p.memWait};
		memAccess = (p.expCs != 4'hF);
		if (!memAccess) begin
			expStall = 0;
		end else if (!p.expCs[0]) begin
			expStall = (waitLen > 1) ? waitLen : 1;   // Slow high RAM adds a first cycle
		end else begin
			expStall = waitLen;
		end

		@(posedge CLK);
		req.addr <= p.addr;
		req.wdata <= p.wdata;
		req.lanes <= p.lanes;
		req.rd <= (p.op == 4'd0);
		req.wr <= (p.op != 4'd0);
		sysResN <= (p.op != 4'd2);
		memRdata <= p.memRdata;
		smpcRdata <= p.smpcRdata;
		scuRdata <= p.scuRdata;
		memWaitN <= (waitLen == 0);
		@(negedge CLK);
		stall = 0;
		while (!rsp.waitN) begin   // Hold the request
			stall++;
			@(posedge CLK);
			memWaitN <= (stall >= waitLen);
			@(negedge CLK);
		end

		checkValue("wait cycles", stall, expStall);
		checkValue("chip selects", {28'd0, romCsN, sramCsN, ramLCsN, ramHCsN}, {28'd0, p.expCs});
		checkValue("memLanes", {28'd0, memLanes}, {28'd0, p.lanes});
		if (p.op == 4'd0) begin
			checkValue("rdata", rsp.rdata, p.expData);
			checkValue("memRdN", {31'd0, memRdN}, {31'd0, !memAccess});
		end else begin
			checkValue("memWdata", memWdata, p.expData);
			checkValue("memRdN", {31'd0, memRdN}, 32'h1);
		end

		@(posedge CLK);   // Completing edge
		req.rd <= 1'b0;
		req.wr <= 1'b0;
		memWaitN <= 1'b1;
		sysResN <= 1'b1;
		@(negedge CLK);
		checkValue("openBus", dut0.openBus, p.expOpenBus);
		checkIdle();

		if (errors == errorsBefore) begin
			$display("test %0d: %s at %h ok", idx, opName(p.op), p.addr);
		end else begin
			$display("test %0d: %s at %h failed", idx, opName(p.op), p.addr);
			testsFailed++;
		end
	endtask

	initial begin
		RST_N = 1'b0;
		sysResN = 1'b1;
		req = '0;
		memRdata = '0;
		memWaitN = 1'b1;
		smpcRdata = '0;
		scuRdata = '0;
		scuWaitN = 1'b1;
		readPatterns();
		cycleLimit = 20 * patCount + resetCycles + 4;
		repeat (resetCycles) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);
		checkIdle();
		checkValue("rdata after reset", rsp.rdata, 32'hFFFF_FFFF);
		for (int i = 0; i < patCount; i++) begin
			runAccess(i);
		end
		$display("%0d tests run, %0d failed, %0d check errors", patCount, testsFailed, errors);
		if (errors == 0 && patCount > 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb/saturnBusGluePatterns.txt ====
# op addr lanes wdata memRdata smpcRdata scuRdata memWait expData expCs expOpenBus (all hex)
# op: 0 read, 1 write, 2 write with sysResN low; expData is memWdata for writes
# expCs bits: romCsN sramCsN ramLCsN ramHCsN
0 4000000 F 00000000 12345678 5A 9ABCDEF0 0 FFFFFFFF F FFFFFFFF
0 0001000 F 00000000 11223344 5A 9ABCDEF0 0 11223344 7 11223344
0 4000000 F 00000000 00000000 00 00000000 0 11223344 F 11223344
0 0100010 F 00000000 99999999 A5 9ABCDEF0 0 0000FFA5 F 0000FFA5
0 4000004 F 00000000 00000000 00 00000000 0 0000FFA5 F 0000FFA5
0 0180004 F 00000000 55667788 00 00000000 0 55667788 B 55667788
0 0200100 F 00000000 0BADF00D 00 00000000 2 0BADF00D D 0BADF00D
0 5FE0010 F 00000000 77777777 00 CAFEBABE 3 CAFEBABE F CAFEBABE
0 6000020 F 00000000 DEADBEEF 00 00000000 0 DEADBEEF E DEADBEEF
0 7FFFFFC F 00000000 13579BDF 00 00000000 3 13579BDF E 13579BDF
0 4000008 F 00000000 00000000 00 00000000 0 13579BDF F 13579BDF
1 0180008 5 AABBCCDD 00000000 00 00000000 0 13BB9BDD B 13BB9BDD
0 400000C F 00000000 00000000 00 00000000 0 13BB9BDD F 13BB9BDD
1 018000C C 01020304 00000000 00 00000000 2 01029BDD B 01029BDD
0 4000010 F 00000000 00000000 00 00000000 0 01029BDD F 01029BDD
1 4000014 F 76543210 00000000 00 00000000 0 76543210 F 76543210
0 4000018 F 00000000 00000000 00 00000000 0 76543210 F 76543210
2 0180010 F FFEEDDCC 00000000 00 00000000 0 FFEEDDCC B 76543210
2 400001C 3 00001111 00000000 00 00000000 0 76541111 F 76543210
0 4000020 F 00000000 00000000 00 00000000 0 76543210 F 76543210
1 6000100 F 24681357 00000000 00 00000000 0 24681357 E 24681357
0 4000024 F 00000000 00000000 00 00000000 0 24681357 F 24681357
0 00FFFFC F 00000000 0F0F0F0F 00 00000000 1 0F0F0F0F 7 0F0F0F0F
0 017FFFF F 00000000 44444444 3C 00000000 2 0000FF3C F 0000FF3C
0 02FFFFC F 00000000 89ABCDEF 00 00000000 0 89ABCDEF D 89ABCDEF
0 0300000 F 00000000 00000000 00 00000000 0 89ABCDEF F 89ABCDEF
0 5FEFFFC F 00000000 00000000 00 00C0FFEE 0 00C0FFEE F 00C0FFEE
0 5FF0000 F 00000000 00000000 00 00000000 0 00C0FFEE F 00C0FFEE
1 0000040 2 0000AB00 00000000 00 00000000 0 00C0ABEE 7 00C0ABEE
0 5FDFFFC F 00000000 00000000 00 00000000 0 00C0ABEE F 00C0ABEE
0 6000000 F 00000000 600DCAFE 00 00000000 1 600DCAFE E 600DCAFE
0 4000028 F 00000000 00000000 00 00000000 0 600DCAFE F 600DCAFE

// ==== saturnBusGlue.f ====
hdl/saturnBusPkg.sv
hdl/saturnMapPkg.sv
hdl/regionDecoder.sv
hdl/openBusLatch.sv
hdl/readDataSelect.sv
hdl/saturnBusGlue.sv
tb/saturnBusGlueTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = saturnBusGlueTb
FILELIST = saturnBusGlue.f
BUILD    = obj_dir

.PHONY: simulate clean

# The run passes only if the pass message shows up in the output
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)
